// File: wb_subsys.f
rv_isa_pkg.sv
wb_ctrl_pkg.sv
wb_result_fmt.sv
gpr_file.sv
store_unit.sv
wb_stage.sv
tb_wb_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the write-back testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps \
    -f wb_subsys.f \
    --top-module tb_wb_stage \
    -o tb_wb_stage

sim_out=$(./obj_dir/tb_wb_stage)
echo "$sim_out"

if grep -qx "Regression passed" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi

// File: tb_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_stage
    import rv_isa_pkg::*, wb_ctrl_pkg::*;
();

    localparam int clk_period = 8;
    localparam int addr_w = $clog2(reg_count_default);
    localparam int test_cycles = 200;   // rough sum over all tests
    localparam int margin_cycles = 100;

    typedef logic [addr_w-1:0] addr_t;

    logic                      clk;
    logic                      rst_n;
    logic                      reg_wen;
    addr_t                     reg_waddr;
    logic [xlen-1:0]           ex_result;
    logic [xlen-1:0]           mem_result;
    logic [ld_src_width-1:0]   ld_src;
    logic                      load_hazard;
    logic [ext_code_width-1:0] ext_code;
    logic                      is_store;
    logic                      store_slot;
    logic [imm_width-1:0]      store_imm;
    logic [mask_width-1:0]     store_mask;
    logic                      ebreak;
    logic [pc_width-1:0]       wb_pc;
    addr_t                     dbg_raddr;
    logic                      mem_wen;
    logic [xlen-1:0]           mem_waddr;
    logic [xlen-1:0]           mem_wdata;
    logic [mask_width-1:0]     mem_wmask;
    logic                      halted;
    logic [pc_width-1:0]       wb_delay_pc;
    logic [xlen-1:0]           dbg_rdata;

    logic [xlen-1:0] model_regs [reg_count_default];  // expected register contents
    logic            model_halted;
    int              pass_count = 0;
    int              fail_count = 0;
    string           cur_test;

    wb_stage #(
        .REG_COUNT (reg_count_default)
    ) dut0 (
        .clk (clk), .rst_n (rst_n),
        .reg_wen (reg_wen), .reg_waddr (reg_waddr),
        .ex_result (ex_result), .mem_result (mem_result),
        .ld_src (ld_src), .load_hazard (load_hazard), .ext_code (ext_code),
        .is_store (is_store), .store_slot (store_slot),
        .store_imm (store_imm), .store_mask (store_mask),
        .ebreak (ebreak), .wb_pc (wb_pc), .dbg_raddr (dbg_raddr),
        .mem_wen (mem_wen), .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata), .mem_wmask (mem_wmask),
        .halted (halted), .wb_delay_pc (wb_delay_pc), .dbg_rdata (dbg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // watchdog
    initial begin
        #((test_cycles + margin_cycles) * clk_period);
        $display("timeout: tests did not complete within %0d cycles",
                 test_cycles + margin_cycles);
        $display("Regression failed");
        $finish;
    end

    task automatic check_dword(input string what, input logic [xlen-1:0] exp,
                               input logic [xlen-1:0] act);
        if (exp === act) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_mask(input string what, input logic [mask_width-1:0] exp,
                              input logic [mask_width-1:0] act);
        if (exp === act) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (exp === act) begin
            pass_count++;
        end else begin
            fail_count++;
            $display("** Error [%s] %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic report_test(input int errs_before);
        if (fail_count == errs_before) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d mismatches", cur_test, fail_count - errs_before);
        end
    endtask

    function automatic logic [xlen-1:0] rand_dword();
        return {$urandom, $urandom};
    endfunction

    // load codes pick the memory stage unless execute forwarded
    function automatic logic takes_mem(input logic [ld_src_width-1:0] ld, input logic hz);
        return !hz && (ld == 3'd1 || ld == 3'd2 || ld == 3'd4 || ld == 3'd6);
    endfunction

    function automatic logic [xlen-1:0] apply_ext(input logic [ext_code_width-1:0] code,
                                                 input logic [xlen-1:0] v);
        case (code)
            ext_full:      return v;
            ext_sign_word: return {{32{v[31]}}, v[31:0]};
            ext_sign_half: return {{48{v[15]}}, v[15:0]};
            default:       return {32'h0, v[31:0]};
        endcase
    endfunction

    task automatic idle_inputs();
        reg_wen = 1'b0;
        reg_waddr = '0;
        ex_result = '0;
        mem_result = '0;
        ld_src = '0;
        load_hazard = 1'b0;
        ext_code = ext_full;
        is_store = 1'b0;
        store_slot = 1'b0;
        store_imm = '0;
        store_mask = '0;
        ebreak = 1'b0;
        wb_pc = '0;
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        model_halted = 1'b0;
        for (int i = 0; i < reg_count_default; i++) begin
            model_regs[i] = '0;
        end
    endtask

    // all drive tasks start and end on a falling edge
    task automatic write_reg(input addr_t rd, input logic [xlen-1:0] ex,
                             input logic [xlen-1:0] mem, input logic [ld_src_width-1:0] ld,
                             input logic hz, input logic [ext_code_width-1:0] code);
        logic [xlen-1:0] pick;
        pick = takes_mem(ld, hz) ? mem : ex;
        reg_wen = 1'b1;
        reg_waddr = rd;
        ex_result = ex;
        mem_result = mem;
        ld_src = ld;
        load_hazard = hz;
        ext_code = code;
        @(negedge clk);
        idle_inputs();
        if (!model_halted && rd != '0) begin
            model_regs[rd] = apply_ext(code, pick);
        end
    endtask

    task automatic drive_store(input addr_t base_rd, input logic [imm_width-1:0] imm,
                               input logic [mask_width-1:0] mask,
                               input logic [xlen-1:0] data, input logic slot);
        reg_wen = 1'b1;
        is_store = 1'b1;
        store_slot = slot;
        reg_waddr = base_rd;
        store_imm = imm;
        store_mask = mask;
        ex_result = data;
        @(negedge clk);
        idle_inputs();
    endtask

    task automatic read_check(input addr_t rd, input string what);
        dbg_raddr = rd;
        @(negedge clk);
        check_dword(what, model_regs[rd], dbg_rdata);
    endtask

    task automatic test_reset();
        int errs;
        errs = fail_count;
        cur_test = "reset";
        check_bit("mem_wen", 1'b0, mem_wen);
        check_bit("halted", 1'b0, halted);
        check_dword("wb_delay_pc", '0, wb_delay_pc);
        for (int i = 0; i < reg_count_default; i++) begin
            read_check(addr_t'(i), $sformatf("x%0d", i));
        end
        report_test(errs);
    endtask

    task automatic test_select();
        int    errs;
        addr_t rd;
        errs = fail_count;
        cur_test = "select";
        for (int ld = 0; ld < 8; ld++) begin
            for (int hz = 0; hz < 2; hz++) begin
                rd = addr_t'(1 + ld * 2 + hz);
                write_reg(rd, rand_dword(), rand_dword(), 3'(ld), hz[0], ext_full);
                read_check(rd, $sformatf("ld_src=%0d hazard=%0d", ld, hz));
            end
        end
        report_test(errs);
    endtask

    task automatic test_extend();
        logic [ext_code_width-1:0] codes [5];
        logic [xlen-1:0]           data;
        addr_t                     rd;
        int                        errs;
        codes = '{ext_full, ext_sign_word, ext_zero_word, ext_sign_half, 4'd9};
        errs = fail_count;
        cur_test = "extend";
        for (int k = 0; k < 5; k++) begin
            for (int j = 0; j < 2; j++) begin
                data = rand_dword();
                data[31] = (j == 0);  // both signs for each code
                data[15] = (j == 0);
                rd = addr_t'(20 + k * 2 + j);
                write_reg(rd, data, rand_dword(), 3'd0, 1'b0, codes[k]);
                read_check(rd, $sformatf("ext_code=%0d", codes[k]));
            end
        end
        write_reg('0, rand_dword(), '0, 3'd0, 1'b0, ext_full);
        read_check('0, "x0 stays zero");
        report_test(errs);
    endtask

    task automatic test_store();
        logic [xlen-1:0]       base;
        logic [xlen-1:0]       data;
        logic [imm_width-1:0]  imm;
        logic [mask_width-1:0] mask;
        int                    errs;
        errs = fail_count;
        cur_test = "store";
        for (int i = 0; i < 4; i++) begin
            base = rand_dword();
            data = rand_dword();
            imm = (i % 2 == 0) ? ($urandom | 32'h8000_0000) : ($urandom & 32'h7fff_ffff);
            mask = 8'($urandom);
            write_reg(addr_t'(9), base, '0, 3'd0, 1'b0, ext_full);
            drive_store(addr_t'(9), imm, mask, data, 1'b1);
            check_bit("mem_wen pulse", 1'b1, mem_wen);
            check_dword("mem_waddr", base + {{32{imm[31]}}, imm}, mem_waddr);
            check_dword("mem_wdata", data, mem_wdata);
            check_mask("mem_wmask", mask, mem_wmask);
            @(negedge clk);
            check_bit("mem_wen drop", 1'b0, mem_wen);
            read_check(addr_t'(9), "base unchanged");
        end
        drive_store(addr_t'(9), 32'h40, 8'hff, rand_dword(), 1'b0);
        check_bit("slot low", 1'b0, mem_wen);
        drive_store('0, 32'h40, 8'hff, rand_dword(), 1'b1);
        check_bit("x0 base", 1'b0, mem_wen);
        read_check(addr_t'(9), "base after blocked stores");
        report_test(errs);
    endtask

    task automatic test_pc_delay();
        logic [pc_width-1:0] pc;
        logic [pc_width-1:0] prev_pc;
        int                  errs;
        errs = fail_count;
        cur_test = "pc_delay";
        prev_pc = wb_pc;  // idle pc held over the last cycle
        for (int i = 0; i < 16; i++) begin
            pc = rand_dword();
            wb_pc = pc;
            #(clk_period / 4);  // low phase, before the capturing edge
            check_dword("wb_delay_pc held", prev_pc, wb_delay_pc);
            @(negedge clk);
            check_dword("wb_delay_pc", pc, wb_delay_pc);
            prev_pc = pc;
        end
        wb_pc = '0;
        report_test(errs);
    endtask

    task automatic test_halt();
        int errs;
        errs = fail_count;
        cur_test = "halt";
        write_reg(addr_t'(7), rand_dword(), '0, 3'd0, 1'b0, ext_full);
        ebreak = 1'b1;
        @(negedge clk);
        ebreak = 1'b0;
        check_bit("halted set", 1'b1, halted);
        model_halted = 1'b1;
        write_reg(addr_t'(7), rand_dword(), '0, 3'd0, 1'b0, ext_full);
        read_check(addr_t'(7), "write blocked");
        drive_store(addr_t'(7), 32'h10, 8'hff, rand_dword(), 1'b1);
        check_bit("store blocked", 1'b0, mem_wen);
        repeat (3) @(negedge clk);
        check_bit("halted held", 1'b1, halted);
        apply_reset();
        check_bit("halted cleared", 1'b0, halted);
        read_check(addr_t'(7), "cleared by reset");
        report_test(errs);
    endtask

    initial begin
        void'($urandom(32'h22d0_65b4));
        rst_n = 1'b0;
        dbg_raddr = '0;
        idle_inputs();
        apply_reset();
        test_reset();
        test_select();
        test_extend();
        test_store();
        test_pc_delay();
        test_halt();
        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_wb_stage

`default_nettype wire

// File: wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module wb_stage
    import rv_isa_pkg::*, wb_ctrl_pkg::*;
#(
    parameter int REG_COUNT = reg_count_default,
    localparam int ADDR_W = $clog2(REG_COUNT)
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,

    input  wire logic                      reg_wen,
    input  wire logic [ADDR_W-1:0]         reg_waddr,   // rd, or store base
    input  wire logic [xlen-1:0]           ex_result,
    input  wire logic [xlen-1:0]           mem_result,
    input  wire logic [ld_src_width-1:0]   ld_src,
    input  wire logic                      load_hazard,
    input  wire logic [ext_code_width-1:0] ext_code,

    input  wire logic                      is_store,
    input  wire logic                      store_slot,
    input  wire logic [imm_width-1:0]      store_imm,
    input  wire logic [mask_width-1:0]     store_mask,

    input  wire logic                      ebreak,
    input  wire logic [pc_width-1:0]       wb_pc,

    input  wire logic [ADDR_W-1:0]         dbg_raddr,

    output logic                           mem_wen,
    output logic      [xlen-1:0]           mem_waddr,
    output logic      [xlen-1:0]           mem_wdata,
    output logic      [mask_width-1:0]     mem_wmask,
    output logic                           halted,
    output logic      [pc_width-1:0]       wb_delay_pc,
    output logic      [xlen-1:0]           dbg_rdata
);

    logic [xlen-1:0] wb_data;
    logic [xlen-1:0] base_data;
    logic            gpr_wen;
    logic            store_req;

    // stores never write rd
    assign gpr_wen   = reg_wen && !is_store && !halted;
    assign store_req = reg_wen && is_store && store_slot &&
                       (reg_waddr != '0) && !halted;

    // sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (ebreak) begin
            halted <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_delay_pc <= '0;
        end else begin
            wb_delay_pc <= wb_pc;  // pc of the instruction just retired
        end
    end

    wb_result_fmt u_fmt (
        .ex_result   (ex_result),
        .mem_result  (mem_result),
        .ld_src      (ld_src),
        .load_hazard (load_hazard),
        .ext_code    (ext_code),
        .wb_data     (wb_data)
    );

    gpr_file #(
        .REG_COUNT (REG_COUNT)
    ) u_gpr (
        .clk       (clk),
        .rst_n     (rst_n),
        .gpr_wen   (gpr_wen),
        .waddr     (reg_waddr),
        .wdata     (wb_data),
        .base_addr (reg_waddr),
        .base_data (base_data),
        .dbg_raddr (dbg_raddr),
        .dbg_rdata (dbg_rdata)
    );

    // store data is the formatted write-back word
    store_unit u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .store_req  (store_req),
        .base_data  (base_data),
        .store_imm  (store_imm),
        .store_data (wb_data),
        .store_mask (store_mask),
        .mem_wen    (mem_wen),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .mem_wmask  (mem_wmask)
    );

endmodule : wb_stage

`default_nettype wire

// File: store_unit.sv
`timescale 1ns/1ps
`default_nettype none

module store_unit
    import rv_isa_pkg::*;
(
    input  wire logic                  clk,
    input  wire logic                  rst_n,

    input  wire logic                  store_req,  // already qualified by the stage
    input  wire logic [xlen-1:0]       base_data,
    input  wire logic [imm_width-1:0]  store_imm,
    input  wire logic [xlen-1:0]       store_data,
    input  wire logic [mask_width-1:0] store_mask,

    output logic                       mem_wen,
    output logic      [xlen-1:0]       mem_waddr,
    output logic      [xlen-1:0]       mem_wdata,
    output logic      [mask_width-1:0] mem_wmask
);

    logic [xlen-1:0] imm_sext;
    logic [xlen-1:0] store_addr;

    // offset is signed, so negative displacements work
    assign imm_sext   = {{(xlen-imm_width){store_imm[imm_width-1]}}, store_imm};
    assign store_addr = base_data + imm_sext;

    // strobe lasts one cycle unless another request follows
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_wen <= 1'b0;
        end else begin
            mem_wen <= store_req;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (store_req) begin
            mem_waddr <= store_addr;
            mem_wdata <= store_data;
            mem_wmask <= store_mask;
        end
    end

endmodule : store_unit

`default_nettype wire

// File: gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

module gpr_file
    import rv_isa_pkg::*;
#(
    parameter int REG_COUNT = reg_count_default,
    localparam int ADDR_W = $clog2(REG_COUNT)
) (
    input  wire logic              clk,
    input  wire logic              rst_n,

    input  wire logic              gpr_wen,
    input  wire logic [ADDR_W-1:0] waddr,
    input  wire logic [xlen-1:0]   wdata,

    // port a, store base
    input  wire logic [ADDR_W-1:0] base_addr,
    output logic      [xlen-1:0]   base_data,

    // port b, debug view
    input  wire logic [ADDR_W-1:0] dbg_raddr,
    output logic      [xlen-1:0]   dbg_rdata
);

    logic [xlen-1:0] regs [REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr_wen && (waddr != '0)) begin // x0 never written
            regs[waddr] <= wdata;
        end
    end

    // reads are combinational, x0 forced to zero
    always_comb begin
        if (base_addr == '0) begin
            base_data = '0;
        end else begin
            base_data = regs[base_addr];
        end
    end

    always_comb begin
        if (dbg_raddr == '0) begin
            dbg_rdata = '0;
        end else begin
            dbg_rdata = regs[dbg_raddr];
        end
    end

endmodule : gpr_file

`default_nettype wire

// File: wb_result_fmt.sv
`timescale 1ns/1ps
`default_nettype none

module wb_result_fmt
    import rv_isa_pkg::*, wb_ctrl_pkg::*;
(
    input  wire logic [xlen-1:0]           ex_result,
    input  wire logic [xlen-1:0]           mem_result,
    input  wire logic [ld_src_width-1:0]   ld_src,
    input  wire logic                      load_hazard,
    input  wire logic [ext_code_width-1:0] ext_code,
    output logic      [xlen-1:0]           wb_data
);

    logic     is_load;
    wb_word_u sel_word;

    always_comb begin
        is_load = (ld_src == ld_src_byte) || (ld_src == ld_src_half) ||
                  (ld_src == ld_src_word) || (ld_src == ld_src_dword);
    end

    // hazard means execute already forwarded the value
    always_comb begin
        if (is_load && !load_hazard) begin
            sel_word.dword = mem_result;
        end else begin
            sel_word.dword = ex_result;
        end
    end

    always_comb begin
        case (ext_code)
            ext_full: begin
                wb_data = sel_word.dword;
            end
            ext_sign_word: begin
                wb_data = {{(xlen-word_width){sel_word.parts.lo_word[word_width-1]}},
                           sel_word.parts.lo_word};
            end
            ext_sign_half: begin
                wb_data = {{(xlen-16){sel_word.parts.lo_word[15]}},
                           sel_word.parts.lo_word[15:0]};
            end
            default: begin // ext_zero_word and unused codes
                wb_data = {{(xlen-word_width){1'b0}}, sel_word.parts.lo_word};
            end
        endcase
    end

endmodule : wb_result_fmt

`default_nettype wire

// File: wb_ctrl_pkg.sv
`default_nettype none

package wb_ctrl_pkg;

    localparam int ext_code_width = 4;
    localparam int ld_src_width = 3;
    localparam int word_width = 32;

    // width extension applied before commit
    localparam logic [ext_code_width-1:0] ext_full = 4'd0;      // jalr, ld, 64-bit alu
    localparam logic [ext_code_width-1:0] ext_sign_word = 4'd1; // lw, addw, divw
    localparam logic [ext_code_width-1:0] ext_zero_word = 4'd2; // lwu
    localparam logic [ext_code_width-1:0] ext_sign_half = 4'd3; // lh
    // codes above 3 fall back to the zero-word rule

    // load buffer codes that mean the result comes from the memory stage
    localparam logic [ld_src_width-1:0] ld_src_byte = 3'd1;
    localparam logic [ld_src_width-1:0] ld_src_half = 3'd2;
    localparam logic [ld_src_width-1:0] ld_src_word = 3'd4;
    localparam logic [ld_src_width-1:0] ld_src_dword = 3'd6;

    typedef struct packed {
        logic [word_width-1:0] hi_word;
        logic [word_width-1:0] lo_word;
    } wb_parts_t;

    // write-back word, read whole or split into halves
    typedef union packed {
        logic [2*word_width-1:0] dword;
        wb_parts_t parts;
    } wb_word_u;

endpackage : wb_ctrl_pkg

`default_nettype wire

// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // integer data path width
    localparam int xlen = 64;

    // full RV64I file; 16 gives an RV64E style file
    localparam int reg_count_default = 32;

    // store offset as carried down from decode
    localparam int imm_width = 32;

    // one strobe bit per byte lane of a double word
    localparam int mask_width = xlen / 8;

    localparam int pc_width = 64;

endpackage : rv_isa_pkg

`default_nettype wire
